/* flist.f */
+incdir+design
design/axi_mon_pkg.sv
design/axi_reset_seq.sv
design/axi_stub_responder.sv
design/axi_txn_log.sv
design/axi_mon_top.sv
verif/tb_axi_mon.sv

/* Bender.yml */
package:
  name: axi_mon

export_include_dirs:
  - design

sources:
  - files:
      - design/axi_mon_pkg.sv
      - design/axi_reset_seq.sv
      - design/axi_stub_responder.sv
      - design/axi_txn_log.sv
      - design/axi_mon_top.sv
  - target: test
    files:
      - verif/tb_axi_mon.sv

/* verif/tb_axi_mon.sv */
`timescale 1ns/10ps

`include "axi_mon_config.svh"

module tb_axi_mon;

    import axi_mon_pkg::*;

    localparam int DRIVE_DLY  = 1;
    localparam int SAMPLE_DLY = 3;
    localparam int TIMEOUT    = 100;

    logic                   axi_clk;
    logic                   pci_reset;
    logic                   i_mmcm_lock;
    logic                   o_axi_rst;
    axi_addr_t              i_ar;
    logic                   i_arvalid;
    logic                   o_arready;
    logic                   o_rvalid;
    logic [`AXI_DATA_W-1:0] o_rdata;
    logic [1:0]             o_rresp;
    logic                   o_rlast;
    logic                   i_rready;
    axi_addr_t              i_aw;
    logic                   i_awvalid;
    logic                   o_awready;
    axi_w_t                 i_w;
    logic                   i_wvalid;
    logic                   o_wready;
    logic                   o_bvalid;
    logic [1:0]             o_bresp;
    logic                   i_bready;
    log_sel_e               i_log_sel;
    logic [`LOG_IDX_W-1:0]  i_log_idx;
    log_word_u              o_log_word;

    // Reference logs, newest at the front
    axi_addr_t   aw_q[$];
    axi_addr_t   ar_q[$];
    axi_w_t      w_q[$];
    logic [31:0] lfsr = 32'hb345;
    int          errors;
    int          test_start;
    int          n_pass;
    int          n_fail;

    axi_mon_top i_dut (.*);

    initial begin
        axi_clk = 1'b0;
        forever #4 axi_clk = ~axi_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic axi_addr_t rand_addr();
        logic [63:0] v;
        v = rand_bits($bits(axi_addr_t));
        return v[$bits(axi_addr_t)-1:0];
    endfunction

    function automatic axi_w_t rand_w();
        axi_w_t      w;
        logic [63:0] v;
        w.data = rand_bits(64);
        v      = rand_bits(9);
        w.strb = v[8:1];
        w.last = v[0];
        return w;
    endfunction

    task automatic tick();
        @(posedge axi_clk);
        #DRIVE_DLY;
    endtask

    task automatic settle();
        #(SAMPLE_DLY - DRIVE_DLY);
    endtask

    function automatic logic probe(input string name);
        case (name)
            "o_axi_rst": return o_axi_rst;
            "o_arready": return o_arready;
            "o_rvalid":  return o_rvalid;
            "o_awready": return o_awready;
            "o_bvalid":  return o_bvalid;
            default:     return 1'bx;
        endcase
    endfunction

    task automatic timeout_abort(input string name);
        $display("Timeout: %s never reached the expected level", name);
        $display("Simulation failed");
        $finish;
    endtask

    // Returns at a sample point with the level seen, counting edges passed
    task automatic wait_level(input string name, input logic level, output int cycles);
        cycles = 0;
        settle();
        while (probe(name) !== level && cycles < TIMEOUT) begin
            @(posedge axi_clk);
            #SAMPLE_DLY;
            cycles++;
        end
        if (probe(name) !== level) timeout_abort(name);
    endtask

    task automatic check_val(input string name, input logic [72:0] got,
                             input logic [72:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start) begin
            n_pass++;
            $display("PASS %s", name);
        end else begin
            n_fail++;
            $display("FAIL %s with %0d errors", name, errors - test_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Transactions and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic do_read(input axi_addr_t ar);
        int n;
        tick();
        i_ar      = ar;
        i_arvalid = 1'b1;
        i_rready  = 1'b1;
        wait_level("o_arready", 1'b1, n);
        tick();
        i_arvalid = 1'b0;
        ar_q.push_front(ar);
        if (ar_q.size() > `LOG_DEPTH) void'(ar_q.pop_back());
        wait_level("o_rvalid", 1'b1, n);
        wait_level("o_rvalid", 1'b0, n);
    endtask

    task automatic do_write(input axi_addr_t aw, input axi_w_t w);
        int n;
        tick();
        i_aw      = aw;
        i_w       = w;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        i_bready  = 1'b1;
        wait_level("o_awready", 1'b1, n);
        tick();
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        aw_q.push_front(aw);
        if (aw_q.size() > `LOG_DEPTH) void'(aw_q.pop_back());
        w_q.push_front(w);
        if (w_q.size() > `LOG_DEPTH) void'(w_q.pop_back());
        wait_level("o_bvalid", 1'b1, n);
        wait_level("o_bvalid", 1'b0, n);
    endtask

    // Address entries carry a zero pad above the beat
    function automatic log_word_u expected_word(input log_sel_e sel, input int idx);
        log_word_u word;
        word = '0;
        case (sel)
            LOG_AW:  if (idx < aw_q.size()) word.addr.beat = aw_q[idx];
            LOG_AR:  if (idx < ar_q.size()) word.addr.beat = ar_q[idx];
            LOG_W:   if (idx < w_q.size()) word.w = w_q[idx];
            default: word = '0;
        endcase
        return word;
    endfunction

    task automatic check_all_logs();
        log_sel_e sel;
        for (int s = 0; s < 3; s++) begin
            for (int idx = 0; idx < `LOG_DEPTH; idx++) begin
                sel = log_sel_e'(s);
                tick();
                i_log_sel = sel;
                i_log_idx = idx[`LOG_IDX_W-1:0];
                settle();
                check_val($sformatf("o_log_word[%s][%0d]", sel.name(), idx),
                          o_log_word, expected_word(sel, idx));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_release();
        int n;
        begin_test();
        // Valids high to show that nothing is accepted before release
        tick();
        i_arvalid = 1'b1;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        repeat (20) begin
            tick();
            settle();
            check_val("o_axi_rst", o_axi_rst, 1'b1);
            check_val("o_arready", o_arready, 1'b0);
            check_val("o_awready", o_awready, 1'b0);
            check_val("o_wready", o_wready, 1'b0);
            check_val("o_rvalid", o_rvalid, 1'b0);
            check_val("o_bvalid", o_bvalid, 1'b0);
        end
        tick();
        i_arvalid = 1'b0;
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        tick();
        i_mmcm_lock = 1'b1;
        wait_level("o_axi_rst", 1'b0, n);
        check_val("edges to o_axi_rst release", n, `RST_DELAY);
        end_test("reset_release");
    endtask

    task automatic test_read_response();
        axi_addr_t ar;
        int        n;
        begin_test();
        ar = rand_addr();
        tick();
        i_ar      = ar;
        i_arvalid = 1'b1;
        i_rready  = 1'b0;
        wait_level("o_arready", 1'b1, n);
        check_val("o_rvalid", o_rvalid, 1'b0);
        tick();
        ar_q.push_front(ar);
        // Second request stays pending while the response is stalled
        i_ar = rand_addr();
        settle();
        check_val("o_rvalid", o_rvalid, 1'b1);
        check_val("o_rdata", o_rdata, `STUB_RDATA);
        check_val("o_rresp", o_rresp, AXI_RESP_OKAY);
        check_val("o_rlast", o_rlast, 1'b1);
        repeat (4) begin
            tick();
            settle();
            check_val("o_rvalid", o_rvalid, 1'b1);
            check_val("o_rdata", o_rdata, `STUB_RDATA);
            check_val("o_arready", o_arready, 1'b0);
        end
        tick();
        i_arvalid = 1'b0;
        i_rready  = 1'b1;
        wait_level("o_rvalid", 1'b0, n);
        check_val("edges to o_rvalid low", n, 1);
        end_test("read_response");
    endtask

    task automatic test_write_pairing();
        axi_addr_t aw;
        axi_w_t    w;
        int        n;
        begin_test();
        aw = rand_addr();
        w  = rand_w();
        tick();
        i_aw      = aw;
        i_awvalid = 1'b1;
        i_bready  = 1'b0;
        repeat (3) begin
            tick();
            settle();
            check_val("o_awready", o_awready, 1'b0);
            check_val("o_wready", o_wready, 1'b0);
        end
        tick();
        i_w      = w;
        i_wvalid = 1'b1;
        wait_level("o_awready", 1'b1, n);
        check_val("o_wready", o_wready, 1'b1);
        tick();
        aw_q.push_front(aw);
        w_q.push_front(w);
        settle();
        check_val("o_bvalid", o_bvalid, 1'b1);
        check_val("o_bresp", o_bresp, AXI_RESP_OKAY);
        repeat (4) begin
            tick();
            settle();
            check_val("o_bvalid", o_bvalid, 1'b1);
            check_val("o_awready", o_awready, 1'b0);
        end
        tick();
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        i_bready  = 1'b1;
        wait_level("o_bvalid", 1'b0, n);
        check_val("edges to o_bvalid low", n, 1);
        end_test("write_pairing");
    endtask

    task automatic test_log_contents();
        begin_test();
        for (int i = 0; i < 11; i++) begin
            do_write(rand_addr(), rand_w());
            do_read(rand_addr());
        end
        check_all_logs();
        end_test("log_contents");
    endtask

    task automatic test_union_decode();
        axi_addr_t ar;
        axi_w_t    w;
        begin_test();
        ar = rand_addr();
        w  = rand_w();
        do_write(rand_addr(), w);
        do_read(ar);
        tick();
        i_log_sel = LOG_AR;
        i_log_idx = '0;
        settle();
        check_val("o_log_word.addr.pad", o_log_word.addr.pad, '0);
        check_val("o_log_word.addr.beat.addr", o_log_word.addr.beat.addr, ar.addr);
        check_val("o_log_word.addr.beat.len", o_log_word.addr.beat.len, ar.len);
        check_val("o_log_word.addr.beat.size", o_log_word.addr.beat.size, ar.size);
        check_val("o_log_word.addr.beat.burst", o_log_word.addr.beat.burst, ar.burst);
        check_val("o_log_word.addr.beat.prot", o_log_word.addr.beat.prot, ar.prot);
        check_val("o_log_word.addr.beat.lock", o_log_word.addr.beat.lock, ar.lock);
        check_val("o_log_word.addr.beat.cache", o_log_word.addr.beat.cache, ar.cache);
        tick();
        i_log_sel = LOG_W;
        settle();
        check_val("o_log_word.w.data", o_log_word.w.data, w.data);
        check_val("o_log_word.w.strb", o_log_word.w.strb, w.strb);
        check_val("o_log_word.w.last", o_log_word.w.last, w.last);
        end_test("union_decode");
    endtask

    // Single-cycle pulse, lock stays high
    task automatic test_reset_clears_log();
        begin_test();
        tick();
        pci_reset = 1'b0;
        tick();
        pci_reset = 1'b1;
        settle();
        check_val("o_axi_rst", o_axi_rst, 1'b1);
        aw_q.delete();
        ar_q.delete();
        w_q.delete();
        check_all_logs();
        end_test("reset_clears_log");
    endtask

    initial begin
        errors      = 0;
        n_pass      = 0;
        n_fail      = 0;
        pci_reset   = 1'b0;
        i_mmcm_lock = 1'b0;
        i_ar        = '0;
        i_aw        = '0;
        i_w         = '0;
        i_arvalid   = 1'b0;
        i_awvalid   = 1'b0;
        i_wvalid    = 1'b0;
        i_rready    = 1'b0;
        i_bready    = 1'b0;
        i_log_sel   = LOG_AW;
        i_log_idx   = '0;
        repeat (10) @(posedge axi_clk);
        #DRIVE_DLY;
        pci_reset = 1'b1;

        test_reset_release();
        test_read_response();
        test_write_pairing();
        test_log_contents();
        test_union_decode();
        test_reset_clears_log();

        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* design/axi_mon_top.sv */
`timescale 1ns/10ps

`include "axi_mon_config.svh"

module axi_mon_top (
    input  logic                   axi_clk,
    input  logic                   pci_reset,
    input  logic                   i_mmcm_lock,
    output logic                   o_axi_rst,

    // AR and R
    input  axi_mon_pkg::axi_addr_t i_ar,
    input  logic                   i_arvalid,
    output logic                   o_arready,
    output logic                   o_rvalid,
    output logic [`AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]             o_rresp,
    output logic                   o_rlast,
    input  logic                   i_rready,

    // AW, W and B
    input  axi_mon_pkg::axi_addr_t i_aw,
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  axi_mon_pkg::axi_w_t    i_w,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    output logic                   o_bvalid,
    output logic [1:0]             o_bresp,
    input  logic                   i_bready,

    // Log readout
    input  axi_mon_pkg::log_sel_e  i_log_sel,
    input  logic [`LOG_IDX_W-1:0]  i_log_idx,
    output axi_mon_pkg::log_word_u o_log_word
);

    logic axi_rst;
    logic ar_fire;
    logic aw_fire;
    logic w_fire;

    assign o_axi_rst = axi_rst;

    axi_reset_seq u_reset_seq (
        .axi_clk     (axi_clk),
        .pci_reset   (pci_reset),
        .i_mmcm_lock (i_mmcm_lock),
        .o_axi_rst   (axi_rst)
    );

    axi_stub_responder u_responder (
        .axi_clk   (axi_clk),
        .pci_reset (pci_reset),
        .i_axi_rst (axi_rst),
        .i_arvalid (i_arvalid),
        .i_rready  (i_rready),
        .o_arready (o_arready),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .o_rlast   (o_rlast),
        .i_awvalid (i_awvalid),
        .i_wvalid  (i_wvalid),
        .i_bready  (i_bready),
        .o_awready (o_awready),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .o_bresp   (o_bresp),
        .o_ar_fire (ar_fire),
        .o_aw_fire (aw_fire),
        .o_w_fire  (w_fire)
    );

    // Beats go to the log straight from the ports
    axi_txn_log u_txn_log (
        .axi_clk    (axi_clk),
        .pci_reset  (pci_reset),
        .i_axi_rst  (axi_rst),
        .i_ar_fire  (ar_fire),
        .i_aw_fire  (aw_fire),
        .i_w_fire   (w_fire),
        .i_ar       (i_ar),
        .i_aw       (i_aw),
        .i_w        (i_w),
        .i_log_sel  (i_log_sel),
        .i_log_idx  (i_log_idx),
        .o_log_word (o_log_word)
    );

endmodule

/* design/axi_txn_log.sv */
`timescale 1ns/10ps

`include "axi_mon_config.svh"

module axi_txn_log (
    input  logic                   axi_clk,
    input  logic                   pci_reset,
    input  logic                   i_axi_rst,

    // Capture side
    input  logic                   i_ar_fire,
    input  logic                   i_aw_fire,
    input  logic                   i_w_fire,
    input  axi_mon_pkg::axi_addr_t i_ar,
    input  axi_mon_pkg::axi_addr_t i_aw,
    input  axi_mon_pkg::axi_w_t    i_w,

    // Readout side
    input  axi_mon_pkg::log_sel_e  i_log_sel,
    input  logic [`LOG_IDX_W-1:0]  i_log_idx,
    output axi_mon_pkg::log_word_u o_log_word
);

    import axi_mon_pkg::*;

    // Address logs share one array, one row per channel
    localparam int ADDR_CH = 2;
    localparam int CH_AW   = 0;
    localparam int CH_AR   = 1;

    axi_addr_t addr_log  [ADDR_CH][`LOG_DEPTH];
    axi_w_t    w_log     [`LOG_DEPTH];
    logic      addr_fire [ADDR_CH];
    axi_addr_t addr_beat [ADDR_CH];

    assign addr_fire[CH_AW] = i_aw_fire;
    assign addr_fire[CH_AR] = i_ar_fire;
    assign addr_beat[CH_AW] = i_aw;
    assign addr_beat[CH_AR] = i_ar;

    ////////////////////////////////////////////////////////////////////////////
    // Capture, newest at index 0
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_clk) begin
        if (!pci_reset || i_axi_rst) begin
            for (int c = 0; c < ADDR_CH; c++) begin
                for (int i = 0; i < `LOG_DEPTH; i++) begin
                    addr_log[c][i] <= '0;
                end
            end
            for (int i = 0; i < `LOG_DEPTH; i++) begin
                w_log[i] <= '0;
            end
        end else begin
            for (int c = 0; c < ADDR_CH; c++) begin
                if (addr_fire[c]) begin
                    for (int i = `LOG_DEPTH-1; i > 0; i--) begin
                        addr_log[c][i] <= addr_log[c][i-1];
                    end
                    addr_log[c][0] <= addr_beat[c];
                end
            end
            // Oldest entry falls off the end
            if (i_w_fire) begin
                for (int i = `LOG_DEPTH-1; i > 0; i--) begin
                    w_log[i] <= w_log[i-1];
                end
                w_log[0] <= i_w;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readout
    ////////////////////////////////////////////////////////////////////////////

    // Pad bits stay zero for address entries
    always_comb begin
        o_log_word = '0;
        case (i_log_sel)
            LOG_AW:  o_log_word.addr.beat = addr_log[CH_AW][i_log_idx];
            LOG_AR:  o_log_word.addr.beat = addr_log[CH_AR][i_log_idx];
            LOG_W:   o_log_word.w = w_log[i_log_idx];
            default: o_log_word = '0;
        endcase
    end

    a_log_sel_valid : assert property (
        @(posedge axi_clk) disable iff (!pci_reset)
        i_log_sel inside {LOG_AW, LOG_AR, LOG_W}
    );

endmodule

/* design/axi_stub_responder.sv */
`timescale 1ns/10ps

`include "axi_mon_config.svh"

module axi_stub_responder (
    input  logic                   axi_clk,
    input  logic                   pci_reset,
    input  logic                   i_axi_rst,

    // Read channels
    input  logic                   i_arvalid,
    input  logic                   i_rready,
    output logic                   o_arready,
    output logic                   o_rvalid,
    output logic [`AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]             o_rresp,
    output logic                   o_rlast,

    // Write channels
    input  logic                   i_awvalid,
    input  logic                   i_wvalid,
    input  logic                   i_bready,
    output logic                   o_awready,
    output logic                   o_wready,
    output logic                   o_bvalid,
    output logic [1:0]             o_bresp,

    // Handshake strobes for the log
    output logic                   o_ar_fire,
    output logic                   o_aw_fire,
    output logic                   o_w_fire
);

    import axi_mon_pkg::*;

    logic rvalid_q;
    logic bvalid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////////////////////

    // One read in flight
    assign o_arready = !rvalid_q && !i_axi_rst;
    assign o_ar_fire = i_arvalid && o_arready;

    always_ff @(posedge axi_clk) begin
        if (!pci_reset || i_axi_rst) begin
            rvalid_q <= 1'b0;
        end else if (rvalid_q && i_rready) begin
            rvalid_q <= 1'b0;
        end else if (o_ar_fire) begin
            rvalid_q <= 1'b1;
        end
    end

    // Fixed single-beat response
    assign o_rvalid = rvalid_q;
    assign o_rdata  = `STUB_RDATA;
    assign o_rresp  = AXI_RESP_OKAY;
    assign o_rlast  = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////////////////////

    // Address and data taken together, never one without the other
    assign o_awready = i_awvalid && i_wvalid && !bvalid_q && !i_axi_rst;
    assign o_wready  = o_awready;
    assign o_aw_fire = i_awvalid && o_awready;
    assign o_w_fire  = i_wvalid && o_wready;

    always_ff @(posedge axi_clk) begin
        if (!pci_reset || i_axi_rst) begin
            bvalid_q <= 1'b0;
        end else if (bvalid_q && i_bready) begin
            bvalid_q <= 1'b0;
        end else if (o_aw_fire) begin
            bvalid_q <= 1'b1;
        end
    end

    assign o_bvalid = bvalid_q;
    assign o_bresp  = AXI_RESP_OKAY;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_rvalid_hold : assert property (
        @(posedge axi_clk) disable iff (!pci_reset || i_axi_rst)
        o_rvalid && !i_rready |=> o_rvalid
    );

    // Accepted write leaves a B response pending and blocks the next one
    a_no_aw_while_b : assert property (
        @(posedge axi_clk) disable iff (!pci_reset || i_axi_rst)
        o_aw_fire |=> o_bvalid && !o_awready
    );

endmodule

/* design/axi_reset_seq.sv */
`timescale 1ns/10ps

`include "axi_mon_config.svh"

module axi_reset_seq (
    input  logic axi_clk,
    input  logic pci_reset,
    input  logic i_mmcm_lock,
    output logic o_axi_rst
);

    // Zero when idle, then fills with ones from the bottom
    logic [`RST_DELAY-1:0] rst_shift;

    // Lock is only looked at from idle, so a glitch afterwards
    // does not restart the count
    always_ff @(posedge axi_clk) begin
        if (!pci_reset) begin
            rst_shift <= '0;
        end else if (rst_shift == '0) begin
            if (i_mmcm_lock) begin
                rst_shift <= {{(`RST_DELAY-1){1'b0}}, 1'b1};
            end
        end else begin
            // Saturates at all ones
            rst_shift <= {rst_shift[`RST_DELAY-2:0], 1'b1};
        end
    end

    // Released once the top bit is reached
    assign o_axi_rst = !rst_shift[`RST_DELAY-1];

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Release only ever follows an edge where pci_reset was high
    a_no_release_in_reset : assert property (
        @(posedge axi_clk) $fell(o_axi_rst) |-> $past(pci_reset)
    );

endmodule

/* design/axi_mon_pkg.sv */
`include "axi_mon_config.svh"

package axi_mon_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Channel beats
    ////////////////////////////////////////////////////////////////////////////

    // One address beat, shared by AW and AR
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [2:0]             size;
        logic [1:0]             burst;
        logic [2:0]             prot;
        logic                   lock;
        logic [3:0]             cache;
    } axi_addr_t;

    // One write data beat
    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
        logic                     last;
    } axi_w_t;

    ////////////////////////////////////////////////////////////////////////////
    // Log readout
    ////////////////////////////////////////////////////////////////////////////

    // Address entries are padded up to the width of a write beat
    localparam int LOG_PAD_W = $bits(axi_w_t) - $bits(axi_addr_t);

    typedef struct packed {
        logic [LOG_PAD_W-1:0] pad;
        axi_addr_t            beat;
    } log_addr_entry_t;

    // Code 3 is not a log
    typedef enum logic [1:0] {
        LOG_AW = 2'd0,
        LOG_AR = 2'd1,
        LOG_W  = 2'd2
    } log_sel_e;

    // Same word, decoded by log select
    typedef union packed {
        log_addr_entry_t addr;
        axi_w_t          w;
    } log_word_u;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

/* design/axi_mon_config.svh */
`ifndef AXI_MON_CONFIG_SVH
`define AXI_MON_CONFIG_SVH

// AXI master port widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_LEN_W  8

// Transaction log geometry
`define LOG_DEPTH  8
`define LOG_IDX_W  3

// Cycles from clock lock to release of the AXI-side reset
`define RST_DELAY  16

// Word returned on every read
`define STUB_RDATA 64'h0000_1234_5678_0000

`endif
